// ==== all.f ====
verilog/cpu16_pkg.sv
verilog/alu16.sv
verilog/reg_file16.sv
verilog/pipeline16.sv
verilog/cpu16_top.sv
verification/cpu16_properties.sv
verification/cpu16_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - verilog/cpu16_pkg.sv
  - verilog/alu16.sv
  - verilog/reg_file16.sv
  - verilog/pipeline16.sv
  - verilog/cpu16_top.sv
  - target: simulation
    files:
      - verification/cpu16_properties.sv
      - verification/cpu16_tb.sv

// ==== verification/cpu16_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;
	import cpu16_pkg::*;

	localparam word_t RESET_PC = 16'h0040;
	localparam int    MAX_PROG = 512;

	logic   CLK;
	logic   RSTb;
	word_t  fetch_addr;
	word_t  fetch_data;
	regwr_t wb;

	word_t  prog [MAX_PROG];
	int     prog_len;
	regwr_t exp_wb [MAX_PROG];	// Expected write-backs in program order.
	int     exp_count;
	int     wb_count;
	word_t  shadow [16];
	flags_t shadow_flags;

	cpu16_top #(
		.RESET_PC(RESET_PC)
	) cpu16_top_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.wb         (wb)
	);

	always #5 CLK = ~CLK;

	// Instruction memory, same-cycle read. Past the program it returns NOP.
	assign fetch_data = (fetch_addr - RESET_PC < prog_len) ? prog[fetch_addr - RESET_PC] : '0;

	task automatic emit(input word_t ins);
		prog[prog_len] = ins;
		prog_len++;
	endtask

	task automatic load_reg(input int r, input word_t v);
		emit({OP_IMM, v[15:4]});
		emit({OP_ALU_RI, ALU_MOV, 4'(r), v[3:0]});
	endtask

	// Sets the flags through r7, then the NOP spacing that branches need.
	task automatic flag_op(input alu_op_e op, input word_t v);
		emit({OP_IMM, v[15:4]});
		emit({OP_ALU_RI, op, 4'd7, v[3:0]});
		repeat (3) emit(16'h0000);
	endtask

	task automatic branch_skip(input logic [2:0] cond);
		word_t target;
		target = RESET_PC + word_t'(prog_len + 3);
		emit({OP_IMM, target[15:4]});
		emit({OP_BRANCH, 1'b0, cond, 4'h0, target[3:0]});
		emit({OP_ALU_RI, ALU_ADD, 4'd8, 4'h1});	// Gone when taken.
	endtask

	task automatic build_program();
		word_t target;
		word_t offset;
		for (int r = 1; r <= 4; r++) begin
			load_reg(r, word_t'($urandom));
		end
		// ******************************
		// Dependent chain, all eight ops
		// ******************************
		emit({OP_ALU_RR, ALU_ADD, 4'd1, 4'd2});
		emit({OP_ALU_RR, ALU_SUB, 4'd2, 4'd1});
		emit({OP_ALU_RR, ALU_AND, 4'd3, 4'd2});
		emit({OP_ALU_RR, ALU_OR,  4'd4, 4'd3});
		emit({OP_ALU_RR, ALU_XOR, 4'd1, 4'd4});
		emit({OP_ALU_RR, ALU_MOV, 4'd5, 4'd1});
		emit({OP_ALU_RR, ALU_SHL, 4'd2, 4'd0});
		emit({OP_ALU_RR, ALU_SHR, 4'd5, 4'd0});
		emit({OP_IMM, 12'hABC});
		emit({OP_ALU_RI, ALU_ADD, 4'd6, 4'h5});
		emit({OP_IMM, 12'h123});
		emit(16'h0000);	// Drops the pending prefix.
		emit({OP_ALU_RI, ALU_OR, 4'd6, 4'h9});
		// ******************************
		// Conditions on three flag states
		// ******************************
		for (int st = 0; st < 3; st++) begin
			for (int c = 0; c < 8; c++) begin
				flag_op(ALU_MOV, (st == 0) ? 16'h0000 : 16'hFFFF);
				if (st == 2) begin
					flag_op(ALU_ADD, 16'h0001);	// Carry out, zero result.
				end
				branch_skip(3'(c));
			end
		end
		// Indirect jump over two flushed slots.
		offset = 16'h0021;
		target = RESET_PC + word_t'(prog_len + 6);
		load_reg(9, target - offset);
		emit({OP_IMM, offset[15:4]});
		emit({OP_BRANCH, 1'b1, COND_ALWAYS, 4'd9, offset[3:0]});
		emit({OP_ALU_RI, ALU_ADD, 4'd8, 4'h1});
		emit({OP_ALU_RI, ALU_ADD, 4'd8, 4'h2});
		emit({OP_ALU_RI, ALU_ADD, 4'd10, 4'h3});
		emit({OP_ALU_RR, ALU_MOV, 4'd11, 4'd9});
	endtask

	function automatic logic [16:0] alu_ref(input logic [3:0] op, input word_t a,
		input word_t b);
		case (op)
			4'h0:    alu_ref = {1'b0, a} + {1'b0, b};
			4'h1:    alu_ref = {a < b, a - b};	// Borrow when b exceeds a.
			4'h2:    alu_ref = {1'b0, a & b};
			4'h3:    alu_ref = {1'b0, a | b};
			4'h4:    alu_ref = {1'b0, a ^ b};
			4'h6:    alu_ref = {a[15], a << 1};
			4'h7:    alu_ref = {a[0], a >> 1};
			default: alu_ref = {1'b0, b};
		endcase
	endfunction

	function automatic logic cond_ref(input logic [2:0] cond, input flags_t f);
		case (cond)
			3'd0:    cond_ref = f.z;
			3'd1:    cond_ref = !f.z;
			3'd2:    cond_ref = f.s;
			3'd3:    cond_ref = !f.s;
			3'd4:    cond_ref = f.c;
			3'd5:    cond_ref = !f.c;
			3'd6:    cond_ref = 1'b1;
			default: cond_ref = 1'b0;
		endcase
	endfunction

	// Runs the program in order on shadow state.
	task automatic build_expected();
		word_t       pc;
		word_t       ins;
		word_t       imm;
		logic [11:0] pend;
		logic [16:0] r;
		pc = RESET_PC;
		pend = '0;
		exp_count = 0;
		shadow_flags = '0;
		foreach (shadow[i]) shadow[i] = '0;
		while (pc - RESET_PC < prog_len) begin
			ins = prog[pc - RESET_PC];
			pc = pc + 1'b1;
			imm = {pend, ins[3:0]};
			pend = (ins[15:12] == 4'h1) ? ins[11:0] : 12'h000;
			if (ins[15:12] == 4'h2 || ins[15:12] == 4'h3) begin
				r = alu_ref(ins[11:8], shadow[ins[7:4]],
					(ins[15:12] == 4'h2) ? shadow[ins[3:0]] : imm);
				shadow[ins[7:4]] = r[15:0];
				shadow_flags = '{c: r[16], z: (r[15:0] == '0), s: r[15]};
				exp_wb[exp_count] = '{en: 1'b1, addr: ins[7:4], data: r[15:0]};
				exp_count++;
			end else if (ins[15:12] == 4'h4 && cond_ref(ins[10:8], shadow_flags)) begin
				pc = ins[11] ? shadow[ins[7:4]] + imm : imm;
			end
		end
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	always @(posedge CLK) begin
		if (RSTb && wb.en) begin
			wb_count <= wb_count + 1;
		end
	end

	// ******************************
	// Checks
	// ******************************
	reset_quiet: assert property (@(posedge CLK) !RSTb |=> (fetch_addr == RESET_PC) && !wb.en)
		else fail_now($sformatf("Wrong fetch address or a write-back during reset at %0t.", $time));

	wb_extra: assert property (@(posedge CLK) disable iff (!RSTb) wb.en |-> wb_count < exp_count)
		else fail_now($sformatf("More write-backs than the program produces at %0t.", $time));

	wb_value: assert property (@(posedge CLK) disable iff (!RSTb)
		wb.en && wb_count < exp_count |-> wb == exp_wb[wb_count])
		else fail_now($sformatf("[FAIL] %0t wb expected %h actual %h", $time,
			exp_wb[$sampled(wb_count)], $sampled(wb)));

	first_exec: assert property (@(posedge CLK) $rose(RSTb) |-> !cpu16_top_inst.alu_req.valid)
		else fail_now($sformatf("ALU request right after reset release at %0t.", $time));

	initial begin
		CLK = 1'b0;
		RSTb = 1'b0;
		prog_len = 0;
		wb_count = 0;
		void'($urandom(32'h280e_629e));
		build_program();
		build_expected();
		fork
			begin
				#((10 + 40 * prog_len) * 10);
				$display("Timeout, the write-backs did not all arrive.");
				$display("TEST FAILED");
				$fatal(1, "Watchdog expired.");
			end
		join_none
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		wait (wb_count == exp_count);
		repeat (20) @(posedge CLK);	// Room for stray write-backs.
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/cpu16_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16_properties #(
	parameter cpu16_pkg::word_t RESET_PC = '0
) (
	input wire                      CLK,
	input wire                      RSTb,
	input wire cpu16_pkg::word_t    fetch_addr,
	input wire cpu16_pkg::regwr_t   regwr,
	input wire cpu16_pkg::alu_req_t alu_req
);

	// ******************************
	// Reset behaviour
	// ******************************
	reset_pc: assert property (@(posedge CLK) !RSTb |=> fetch_addr == RESET_PC)
		else $error("Fetch address is not the reset address.");

	reset_no_wb: assert property (@(posedge CLK) !RSTb |=> !regwr.en)
		else $error("Register write during reset.");

	// ******************************
	// Pipeline protocol
	// ******************************
	wb_known: assert property (@(posedge CLK) disable iff (!RSTb)
		regwr.en |-> !$isunknown(regwr))
		else $error("Unknown bits on the write-back port.");

	no_early_alu: assert property (@(posedge CLK) $rose(RSTb) |-> !alu_req.valid)
		else $error("ALU request in the first cycle after reset.");

endmodule

bind pipeline16 cpu16_properties #(
	.RESET_PC(RESET_PC)
) cpu16_properties_inst (
	.CLK        (CLK),
	.RSTb       (RSTb),
	.fetch_addr (fetch_addr),
	.regwr      (regwr),
	.alu_req    (alu_req)
);

`default_nettype wire

// ==== verilog/cpu16_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu16_top #(
	parameter cpu16_pkg::word_t RESET_PC = '0	// First fetch address.
) (
	input  wire                   CLK,
	input  wire                   RSTb,
	output cpu16_pkg::word_t      fetch_addr,
	input  wire cpu16_pkg::word_t fetch_data,
	output cpu16_pkg::regwr_t     wb
);
	import cpu16_pkg::*;

	flags_t    flags;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	alu_req_t  alu_req;
	word_t     alu_result;

	pipeline16 #(
		.RESET_PC(RESET_PC)
	) pipeline16_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.flags      (flags),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.alu_req    (alu_req),
		.alu_result (alu_result),
		.regwr      (wb)	// Write-back also leaves the core.
	);

	alu16 alu16_inst (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.alu_req    (alu_req),
		.alu_result (alu_result),
		.flags      (flags)
	);

	reg_file16 reg_file16_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.regwr     (wb)
	);

endmodule

`default_nettype wire

// ==== verilog/pipeline16.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline16 #(
	parameter cpu16_pkg::word_t RESET_PC = '0
) (
	input  wire                      CLK,
	input  wire                      RSTb,
	output cpu16_pkg::word_t         fetch_addr,
	input  wire cpu16_pkg::word_t    fetch_data,
	input  wire cpu16_pkg::flags_t   flags,
	output cpu16_pkg::reg_addr_t     rd_addr_a,
	output cpu16_pkg::reg_addr_t     rd_addr_b,
	input  wire cpu16_pkg::word_t    rd_data_a,
	input  wire cpu16_pkg::word_t    rd_data_b,
	output cpu16_pkg::alu_req_t      alu_req,
	input  wire cpu16_pkg::word_t    alu_result,
	output cpu16_pkg::regwr_t        regwr
);
	import cpu16_pkg::*;

	localparam int    NREGS   = 2**REG_ADDR_W;
	localparam word_t NOP_INS = '0;

	word_t pc_r;
	word_t pc_next;
	word_t pc_prev_r;	// Address of the instruction in stage 1.
	word_t pc_prev_next;

	word_t s1_r;
	word_t s1_next;
	word_t s2_r;
	word_t s2_next;
	word_t s3_r;
	word_t s4_r;

	logic [11:0] imm_r;	// Pending upper immediate.
	logic [11:0] imm_next;
	word_t       imm_full;

	logic [NREGS-1:0] busy2_r;
	logic [NREGS-1:0] busy2_next;
	logic [NREGS-1:0] busy3_r;
	logic [NREGS-1:0] busy4_r;
	logic [NREGS-1:0] busy_any;

	logic taken2_r;
	logic taken2_next;

	word_t op_a2_r;
	word_t op_b2_r;
	word_t op_b_next;
	word_t res3_r;
	word_t res4_r;

	opclass_e cls1;
	opclass_e cls2;
	opclass_e cls4;
	logic     br_taken1;
	logic     br_ind1;
	logic     ind_taken2;
	logic     stall;

	function automatic opclass_e ins_class(input word_t ins);
		case (opclass_e'(ins[15:12]))
			OP_IMM:    ins_class = OP_IMM;
			OP_ALU_RR: ins_class = OP_ALU_RR;
			OP_ALU_RI: ins_class = OP_ALU_RI;
			OP_BRANCH: ins_class = OP_BRANCH;
			default:   ins_class = OP_NOP;
		endcase
	endfunction

	function automatic logic is_alu(input opclass_e cls);
		is_alu = (cls == OP_ALU_RR) || (cls == OP_ALU_RI);
	endfunction

	function automatic logic cond_taken(input word_t ins, input flags_t f);
		case (cond_e'(ins[10:8]))
			COND_Z:      cond_taken = f.z;
			COND_NZ:     cond_taken = !f.z;
			COND_S:      cond_taken = f.s;
			COND_NS:     cond_taken = !f.s;
			COND_C:      cond_taken = f.c;
			COND_NC:     cond_taken = !f.c;
			COND_ALWAYS: cond_taken = 1'b1;
			default:     cond_taken = 1'b0;	// Link is not supported.
		endcase
	endfunction

	// ******************************
	// Stage 1 decode and hazards
	// ******************************

	assign cls1       = ins_class(s1_r);
	assign cls2       = ins_class(s2_r);
	assign cls4       = ins_class(s4_r);
	assign busy_any   = busy2_r | busy3_r | busy4_r;
	assign imm_full   = {imm_r, s1_r[3:0]};
	assign br_ind1    = s1_r[11];
	assign br_taken1  = (cls1 == OP_BRANCH) && cond_taken(s1_r, flags);
	assign ind_taken2 = (cls2 == OP_BRANCH) && s2_r[11] && taken2_r;

	assign fetch_addr = pc_r;
	assign rd_addr_a  = s1_r[7:4];	// Destination or indirect base.
	assign rd_addr_b  = s1_r[3:0];
	assign op_b_next  = (cls1 == OP_ALU_RR) ? rd_data_b : imm_full;

	always_comb begin
		case (cls1)
			OP_ALU_RR: stall = busy_any[s1_r[7:4]] || busy_any[s1_r[3:0]];
			OP_ALU_RI: stall = busy_any[s1_r[7:4]];
			OP_BRANCH: stall = br_taken1 && br_ind1 && busy_any[s1_r[7:4]];
			default:   stall = 1'b0;
		endcase
	end

	always_comb begin
		pc_next      = pc_r + 1'b1;
		pc_prev_next = pc_r;
		s1_next      = fetch_data;
		s2_next      = s1_r;
		imm_next     = (cls1 == OP_IMM) ? s1_r[11:0] : 12'h000;
		busy2_next   = '0;
		taken2_next  = 1'b0;
		if (stall) begin
			pc_next      = pc_prev_r + 1'b1;	// Refetch the word behind it.
			pc_prev_next = pc_prev_r;
			s1_next      = s1_r;
			s2_next      = NOP_INS;	// Bubble.
			imm_next     = imm_r;
		end else begin
			if (is_alu(cls1)) begin
				busy2_next[s1_r[7:4]] = 1'b1;
			end
			if (br_taken1) begin
				taken2_next = 1'b1;
				s1_next     = NOP_INS;	// Flush the slot behind.
				if (!br_ind1) begin
					pc_next = imm_full;
				end
			end
		end
		// Indirect target resolves here and kills a second slot.
		if (ind_taken2) begin
			pc_next = op_a2_r + op_b2_r;
			s1_next = NOP_INS;
		end
	end

	// ******************************
	// Stage 2 execute, stage 4 write-back
	// ******************************

	always_comb begin
		alu_req.op    = alu_op_e'(s2_r[11:8]);
		alu_req.a     = op_a2_r;
		alu_req.b     = op_b2_r;
		alu_req.valid = is_alu(cls2);
	end

	always_comb begin
		regwr.en   = is_alu(cls4);	// One pulse per retiring ALU op.
		regwr.addr = s4_r[7:4];
		regwr.data = res4_r;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc_r      <= RESET_PC;
			pc_prev_r <= RESET_PC;
			s1_r      <= NOP_INS;
			s2_r      <= NOP_INS;
			s3_r      <= NOP_INS;
			s4_r      <= NOP_INS;
			imm_r     <= '0;
			busy2_r   <= '0;
			busy3_r   <= '0;
			busy4_r   <= '0;
			taken2_r  <= 1'b0;
		end else begin
			pc_r      <= pc_next;
			pc_prev_r <= pc_prev_next;
			s1_r      <= s1_next;
			s2_r      <= s2_next;
			s3_r      <= s2_r;
			s4_r      <= s3_r;
			imm_r     <= imm_next;
			busy2_r   <= busy2_next;
			busy3_r   <= busy2_r;
			busy4_r   <= busy3_r;
			taken2_r  <= taken2_next;
		end
	end

	// Operands and results follow the instruction registers.
	always_ff @(posedge CLK) begin
		op_a2_r <= rd_data_a;
		op_b2_r <= op_b_next;
		res3_r  <= alu_result;
		res4_r  <= res3_r;
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file16.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file16 (
	input  wire                       CLK,
	input  wire                       RSTb,
	input  wire cpu16_pkg::reg_addr_t rd_addr_a,
	input  wire cpu16_pkg::reg_addr_t rd_addr_b,
	output cpu16_pkg::word_t          rd_data_a,
	output cpu16_pkg::word_t          rd_data_b,
	input  wire cpu16_pkg::regwr_t    regwr
);
	import cpu16_pkg::*;

	localparam int NREGS = 2**REG_ADDR_W;

	word_t regs [NREGS];

	// Single write port, visible to reads one cycle later.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (regwr.en) begin
			regs[regwr.addr] <= regwr.data;
		end
	end

	// Asynchronous read ports.
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== verilog/alu16.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu16 (
	input  wire                      CLK,
	input  wire                      RSTb,
	input  wire cpu16_pkg::alu_req_t alu_req,
	output cpu16_pkg::word_t         alu_result,
	output cpu16_pkg::flags_t        flags
);
	import cpu16_pkg::*;

	logic [DATA_W:0] wide;	// Result with carry on top.
	logic            carry;
	flags_t          flags_next;

	// ******************************
	// Combinational operation
	// ******************************

	always_comb begin
		wide = '0;
		case (alu_req.op)
			ALU_ADD: begin
				wide = {1'b0, alu_req.a} + {1'b0, alu_req.b};
			end
			ALU_SUB: begin
				wide = {1'b0, alu_req.a} - {1'b0, alu_req.b};	// Top bit is the borrow.
			end
			ALU_AND: begin
				wide = {1'b0, alu_req.a & alu_req.b};
			end
			ALU_OR: begin
				wide = {1'b0, alu_req.a | alu_req.b};
			end
			ALU_XOR: begin
				wide = {1'b0, alu_req.a ^ alu_req.b};
			end
			ALU_SHL: begin
				wide = {alu_req.a, 1'b0};	// MSB falls into carry.
			end
			ALU_SHR: begin
				wide = {alu_req.a[0], 1'b0, alu_req.a[DATA_W-1:1]};	// LSB falls into carry.
			end
			default: begin
				wide = {1'b0, alu_req.b};	// MOV and unused codes.
			end
		endcase
	end

	assign alu_result = wide[DATA_W-1:0];
	assign carry      = wide[DATA_W];

	always_comb begin
		flags_next.c = carry;
		flags_next.z = (alu_result == '0);
		flags_next.s = alu_result[DATA_W-1];
	end

	// Flags only follow operations that actually execute.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			flags <= '0;
		end else if (alu_req.valid) begin
			flags <= flags_next;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpu16_pkg.sv ====
`default_nettype none

package cpu16_pkg;

	// ******************************
	// Widths and basic types
	// ******************************

	localparam int DATA_W     = 16;	// Datapath width.
	localparam int REG_ADDR_W = 4;	// Sixteen registers.

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// ******************************
	// Instruction fields
	// ******************************

	// Instruction class in bits 15:12. Unlisted codes decode as NOP.
	typedef enum logic [3:0] {
		OP_NOP    = 4'h0,
		OP_IMM    = 4'h1,	// Upper 12 bits of the next immediate.
		OP_ALU_RR = 4'h2,
		OP_ALU_RI = 4'h3,
		OP_BRANCH = 4'h4
	} opclass_e;

	// ALU operation in bits 11:8. Codes 8 to 15 act as MOV.
	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,	// Carry holds the borrow.
		ALU_AND = 4'h2,
		ALU_OR  = 4'h3,
		ALU_XOR = 4'h4,
		ALU_MOV = 4'h5,
		ALU_SHL = 4'h6,
		ALU_SHR = 4'h7
	} alu_op_e;

	// Branch condition in bits 10:8.
	typedef enum logic [2:0] {
		COND_Z      = 3'h0,
		COND_NZ     = 3'h1,
		COND_S      = 3'h2,
		COND_NS     = 3'h3,
		COND_C      = 3'h4,
		COND_NC     = 3'h5,
		COND_ALWAYS = 3'h6,
		COND_LINK   = 3'h7	// Never taken.
	} cond_e;

	// ******************************
	// Interfaces between blocks
	// ******************************

	typedef struct packed {
		logic c;
		logic z;
		logic s;
	} flags_t;

	typedef struct packed {
		alu_op_e op;
		word_t   a;	// Destination register value.
		word_t   b;	// Source register or immediate.
		logic    valid;
	} alu_req_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} regwr_t;

endpackage

`default_nettype wire
